// File: source/comm_blk_pkg.sv
// Shared constants and types for the communication block.
// The register window is 4 KB. Only 32-bit word offsets decode to a register.
// RESP_DELAY must be at least 2 for the sequencer delay counter.
package comm_blk_pkg;

  // ====================
  // Address map
  // ====================
  localparam logic [31:0] COMM_BASE      = 32'h4001_6000; // Bits 31..12 select the window
  localparam logic [11:0] OFF_CONTROL    = 12'h000;
  localparam logic [11:0] OFF_STATUS     = 12'h004;
  localparam logic [11:0] OFF_INT_ENABLE = 12'h008;
  localparam logic [11:0] OFF_DATA8      = 12'h010;
  localparam logic [11:0] OFF_DATA32     = 12'h014;
  localparam logic [11:0] OFF_FRAME8     = 12'h018;

  // One-hot register select and its bit indices
  localparam int NUM_REGS       = 6;
  localparam int SEL_CONTROL    = 0;
  localparam int SEL_STATUS     = 1;
  localparam int SEL_INT_ENABLE = 2;
  localparam int SEL_DATA8      = 3;
  localparam int SEL_DATA32     = 4;
  localparam int SEL_FRAME8     = 5;
  typedef logic [NUM_REGS-1:0] reg_sel_t;

  // ====================
  // Register reset values and masks
  // ====================
  localparam logic [7:0] CONTROL_RESET    = 8'h1C;
  localparam logic [7:0] STATUS_RESET     = 8'h01; // tx_ok set
  localparam logic [7:0] INT_ENABLE_RESET = 8'hAF;
  localparam logic [7:0] CONTROL_WMASK    = 8'h3D; // Bits 5..2 and 0
  localparam logic [7:0] STATUS_WMASK     = 8'h7C; // Software bits 6..2

  localparam int ST_CMD    = 7;
  localparam int ST_RX_OK  = 1;
  localparam int ST_TX_OK  = 0;

  // ====================
  // Service command codes
  // ====================
  localparam int CMD_CODE_W         = 8;
  localparam int NUM_DESC_CMDS      = 12;
  localparam int NUM_SHORT_CMDS     = 6;
  localparam int NUM_SELF_TEST_CMDS = 2;

  // Three-phase services, ending in a descriptor pointer
  localparam logic [CMD_CODE_W-1:0] DESC_CMDS [NUM_DESC_CMDS] =
    '{8'd0, 8'd1, 8'd3, 8'd4, 8'd5, 8'd6, 8'd9, 8'd10, 8'd12, 8'd14, 8'd16, 8'd17};
  // Two-phase services
  localparam logic [CMD_CODE_W-1:0] SHORT_CMDS [NUM_SHORT_CMDS] =
    '{8'd8, 8'd23, 8'd25, 8'd31, 8'd40, 8'd45};
  // Started by the frame8 write alone
  localparam logic [CMD_CODE_W-1:0] SELF_TEST_CMDS [NUM_SELF_TEST_CMDS] = '{8'd40, 8'd45};

  // ====================
  // Response sequencer
  // ====================
  localparam int          RESP_DELAY     = 5;
  localparam logic [7:0]  RESP_STATUS_OK = 8'h00;
  localparam logic [31:0] DESC_BASE      = 32'h2000_0100;
  localparam logic [31:0] DESC_STRIDE    = 32'h0000_0040;

  typedef logic [2:0] phase_t;
  localparam phase_t PH_FRAME  = 3'd1; // Command echo in frame8
  localparam phase_t PH_STATUS = 3'd2; // Service status in data8
  localparam phase_t PH_DESC   = 3'd3; // Descriptor pointer in data32

  function automatic logic is_desc_cmd(input logic [CMD_CODE_W-1:0] code);
    logic hit;
    hit = 1'b0;
    foreach (DESC_CMDS[i]) hit |= (code == DESC_CMDS[i]);
    return hit;
  endfunction

  function automatic logic is_short_cmd(input logic [CMD_CODE_W-1:0] code);
    logic hit;
    hit = 1'b0;
    foreach (SHORT_CMDS[i]) hit |= (code == SHORT_CMDS[i]);
    return hit;
  endfunction

  function automatic logic is_self_test_cmd(input logic [CMD_CODE_W-1:0] code);
    logic hit;
    hit = 1'b0;
    foreach (SELF_TEST_CMDS[i]) hit |= (code == SELF_TEST_CMDS[i]);
    return hit;
  endfunction

  // Descriptor pointer of a three-phase service
  function automatic logic [31:0] desc_ptr(input logic [CMD_CODE_W-1:0] code);
    return DESC_BASE + 32'(code) * DESC_STRIDE;
  endfunction

endpackage

// File: source/ahb_slave_if.sv
// AHB-Lite slave front end with address decode.
// Selects are registered from the address phase and live for the data phase only.
// A miss gives HREADY low with HRESP high, then HREADY high with HRESP high.
// The host must hold its next address phase while HREADY is low.
`timescale 1ns/1ps

module ahb_slave_if (
  input  logic                   HCLK,
  input  logic                   HRESETN,
  input  logic                   HSEL,
  input  logic [31:0]            HADDR,
  input  logic [1:0]             HTRANS,
  input  logic                   HWRITE,
  input  logic [31:0]            rd_data,
  output logic                   HREADY,
  output logic                   HRESP,
  output logic [31:0]            HRDATA,
  output comm_blk_pkg::reg_sel_t wr_sel,
  output comm_blk_pkg::reg_sel_t rd_sel
);

  comm_blk_pkg::reg_sel_t addr_sel; // Decoded in the address phase
  logic                   accept;
  logic                   hit;
  logic                   err_first;
  logic                   err_second;

  // NONSEQ or SEQ while selected and ready
  assign accept = HSEL & HREADY & HTRANS[1];

  // ====================
  // Window and offset decode
  // ====================
  always_comb begin
    addr_sel = '0;
    if (HADDR[31:12] == comm_blk_pkg::COMM_BASE[31:12]) begin
      case (HADDR[11:0])
        comm_blk_pkg::OFF_CONTROL:    addr_sel[comm_blk_pkg::SEL_CONTROL]    = 1'b1;
        comm_blk_pkg::OFF_STATUS:     addr_sel[comm_blk_pkg::SEL_STATUS]     = 1'b1;
        comm_blk_pkg::OFF_INT_ENABLE: addr_sel[comm_blk_pkg::SEL_INT_ENABLE] = 1'b1;
        comm_blk_pkg::OFF_DATA8:      addr_sel[comm_blk_pkg::SEL_DATA8]      = 1'b1;
        comm_blk_pkg::OFF_DATA32:     addr_sel[comm_blk_pkg::SEL_DATA32]     = 1'b1;
        comm_blk_pkg::OFF_FRAME8:     addr_sel[comm_blk_pkg::SEL_FRAME8]     = 1'b1;
        default:                      addr_sel = '0; // Hole in the window
      endcase
    end
  end

  assign hit = |addr_sel;

  // ====================
  // Data-phase state
  // ====================
  always_ff @(posedge HCLK or negedge HRESETN) begin
    if (!HRESETN) begin
      wr_sel     <= '0;
      rd_sel     <= '0;
      err_first  <= 1'b0;
      err_second <= 1'b0;
    end else begin
      wr_sel     <= (accept & HWRITE) ? addr_sel : '0;
      rd_sel     <= (accept & ~HWRITE) ? addr_sel : '0;
      err_first  <= accept & ~hit;  // Missed address arms ERROR
      err_second <= err_first;
    end
  end

  // Two-cycle ERROR response, otherwise always ready
  assign HREADY = ~err_first;
  assign HRESP  = err_first | err_second;

  // Register file already returns zero outside a read data phase
  assign HRDATA = rd_data;

endmodule

// File: source/comm_blk_regs.sv
// Control, status, interrupt-enable and mailbox registers.
// Writes land at the end of the data phase. Reads are combinational.
// Status bits 7 and 1 come from the sequencer and cannot be written.
// In phase 2 data8 and in phase 3 data32 read the response word instead of storage.
// The interrupt is registered, one cycle behind its sources.
`timescale 1ns/1ps

module comm_blk_regs (
  input  logic                                HCLK,
  input  logic                                HRESETN,
  input  comm_blk_pkg::reg_sel_t              wr_sel,
  input  comm_blk_pkg::reg_sel_t              rd_sel,
  input  logic [31:0]                         HWDATA,
  input  logic                                cmd_flag,
  input  logic                                rx_ok,
  input  comm_blk_pkg::phase_t                phase,
  input  logic [31:0]                         resp_word,
  output logic [31:0]                         rd_data,
  output logic [comm_blk_pkg::CMD_CODE_W-1:0] cmd_code,
  output logic                                start,
  output logic                                status_rd,
  output logic                                frame8_rd,
  output logic                                data8_rd,
  output logic                                data32_rd,
  output logic                                comm_blk_int
);

  logic [7:0]  control_q;
  logic [7:0]  status_q;    // Software bits and tx_ok
  logic [7:0]  int_enable_q;
  logic [7:0]  data8_q;
  logic [31:0] data32_q;
  logic [7:0]  frame8_q;
  logic [7:0]  status_val;

  // ====================
  // Control registers
  // ====================
  always_ff @(posedge HCLK or negedge HRESETN) begin
    if (!HRESETN) begin
      control_q    <= comm_blk_pkg::CONTROL_RESET;
      status_q     <= comm_blk_pkg::STATUS_RESET;
      int_enable_q <= comm_blk_pkg::INT_ENABLE_RESET;
      data8_q      <= 8'h00;
      data32_q     <= 32'h0;
      frame8_q     <= 8'h00;
      comm_blk_int <= 1'b0;
    end else begin
      if (wr_sel[comm_blk_pkg::SEL_CONTROL])
        control_q <= (control_q & ~comm_blk_pkg::CONTROL_WMASK) |
                     (HWDATA[7:0] & comm_blk_pkg::CONTROL_WMASK);
      if (wr_sel[comm_blk_pkg::SEL_STATUS])
        status_q <= (status_q & ~comm_blk_pkg::STATUS_WMASK) |
                    (HWDATA[7:0] & comm_blk_pkg::STATUS_WMASK);
      if (wr_sel[comm_blk_pkg::SEL_INT_ENABLE])
        int_enable_q <= HWDATA[7:0];
      if (wr_sel[comm_blk_pkg::SEL_DATA8])
        data8_q <= HWDATA[7:0];    // Mailbox payload
      if (wr_sel[comm_blk_pkg::SEL_DATA32])
        data32_q <= HWDATA;
      if (wr_sel[comm_blk_pkg::SEL_FRAME8])
        frame8_q <= HWDATA[7:0];   // Command code of the next service
      comm_blk_int <= |(int_enable_q & status_val);
    end
  end

  // Sequencer flags merged over the stored bits
  assign status_val = {cmd_flag, status_q[6:2], rx_ok, status_q[comm_blk_pkg::ST_TX_OK]};

  // ====================
  // Sequencer hooks
  // ====================
  // Bypass so a self-test write starts with its own code
  assign cmd_code = wr_sel[comm_blk_pkg::SEL_FRAME8] ? HWDATA[7:0] : frame8_q;

  assign start = wr_sel[comm_blk_pkg::SEL_DATA8] |
                 (wr_sel[comm_blk_pkg::SEL_FRAME8] &
                  comm_blk_pkg::is_self_test_cmd(HWDATA[7:0]));

  assign status_rd = rd_sel[comm_blk_pkg::SEL_STATUS];
  assign frame8_rd = rd_sel[comm_blk_pkg::SEL_FRAME8];
  assign data8_rd  = rd_sel[comm_blk_pkg::SEL_DATA8];
  assign data32_rd = rd_sel[comm_blk_pkg::SEL_DATA32];

  // Read multiplexer, zero when no read is in its data phase
  always_comb begin
    rd_data = '0;
    if (rd_sel[comm_blk_pkg::SEL_CONTROL])
      rd_data = {24'h0, control_q};
    else if (status_rd)
      rd_data = {24'h0, status_val};
    else if (rd_sel[comm_blk_pkg::SEL_INT_ENABLE])
      rd_data = {24'h0, int_enable_q};
    else if (data8_rd)
      rd_data = (phase == comm_blk_pkg::PH_STATUS) ? {24'h0, resp_word[7:0]}
                                                   : {24'h0, data8_q};
    else if (data32_rd)
      rd_data = (phase == comm_blk_pkg::PH_DESC) ? resp_word : data32_q;
    else if (frame8_rd)
      rd_data = {24'h0, frame8_q};
  end

endmodule

// File: source/response_sequencer.sv
// Paces one service response at a time through its phases.
// Flags rise RESP_DELAY cycles after start or after the closing read of a phase.
// Each wait for a host read is unbounded. A start while busy is ignored.
// Codes outside the descriptor and short lists are dropped.
`timescale 1ns/1ps

module response_sequencer (
  input  logic                                HCLK,
  input  logic                                HRESETN,
  input  logic                                start,
  input  logic [comm_blk_pkg::CMD_CODE_W-1:0] cmd_code,
  input  logic                                status_rd,
  input  logic                                frame8_rd,
  input  logic                                data8_rd,
  input  logic                                data32_rd,
  output logic                                cmd_flag,
  output logic                                rx_ok,
  output comm_blk_pkg::phase_t                phase,
  output logic [31:0]                         resp_word
);

  // Counter load so the flag lands exactly RESP_DELAY cycles later
  localparam logic [3:0] DELAY_LOAD = 4'(comm_blk_pkg::RESP_DELAY - 2);

  typedef enum logic [1:0] {
    S_IDLE,
    S_DELAY,        // Counting down before rx_ok
    S_WAIT_STATUS,  // rx_ok up, waiting for the status read
    S_WAIT_READ     // Waiting for the read that closes the phase
  } state_t;

  state_t                            state;
  comm_blk_pkg::phase_t              step;      // Phase being served
  logic [3:0]                        delay_cnt;
  logic                              is_desc;
  logic [comm_blk_pkg::CMD_CODE_W-1:0] cmd_q;
  logic                              known;
  logic                              closing_rd;
  logic                              last_phase;

  assign known = comm_blk_pkg::is_desc_cmd(cmd_code) | comm_blk_pkg::is_short_cmd(cmd_code);

  // Mailbox read that ends the current phase
  always_comb begin
    case (step)
      comm_blk_pkg::PH_FRAME:  closing_rd = frame8_rd;
      comm_blk_pkg::PH_STATUS: closing_rd = data8_rd;
      default:                 closing_rd = data32_rd;
    endcase
  end

  // Short services stop after phase 2
  assign last_phase = (step == comm_blk_pkg::PH_DESC) |
                      ((step == comm_blk_pkg::PH_STATUS) & ~is_desc);

  // ====================
  // Phase FSM
  // ====================
  always_ff @(posedge HCLK or negedge HRESETN) begin
    if (!HRESETN) begin
      state     <= S_IDLE;
      step      <= '0;
      delay_cnt <= '0;
      is_desc   <= 1'b0;
      cmd_flag  <= 1'b0;
      rx_ok     <= 1'b0;
      phase     <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (start) begin
            phase     <= '0;
            step      <= comm_blk_pkg::PH_FRAME;
            delay_cnt <= DELAY_LOAD;
            is_desc   <= comm_blk_pkg::is_desc_cmd(cmd_code);
            if (known)
              state <= S_DELAY;
          end
        end
        S_DELAY: begin
          if (delay_cnt == '0) begin
            rx_ok <= 1'b1;
            if (step == comm_blk_pkg::PH_FRAME)
              cmd_flag <= 1'b1;   // Command echo is pending
            state <= S_WAIT_STATUS;
          end else begin
            delay_cnt <= delay_cnt - 4'd1;
          end
        end
        S_WAIT_STATUS: begin
          if (status_rd) begin
            phase <= step;
            state <= S_WAIT_READ;
          end
        end
        S_WAIT_READ: begin
          if (closing_rd) begin
            cmd_flag <= 1'b0;
            rx_ok    <= 1'b0;
            if (last_phase) begin
              state <= S_IDLE;
            end else begin
              step      <= step + 3'd1;
              delay_cnt <= DELAY_LOAD;
              state     <= S_DELAY;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Latched command and response payload
  always_ff @(posedge HCLK) begin
    if (state == S_IDLE && start)
      cmd_q <= cmd_code;
    if (state == S_WAIT_STATUS && status_rd) begin
      if (step == comm_blk_pkg::PH_STATUS)
        resp_word <= {24'h0, comm_blk_pkg::RESP_STATUS_OK};
      else if (step == comm_blk_pkg::PH_DESC)
        resp_word <= comm_blk_pkg::desc_ptr(cmd_q);
    end
  end

endmodule

// File: source/comm_blk_top.sv
// Communication block behind an AHB-Lite slave port.
// Only 32-bit single transfers are meaningful; HSIZE and HBURST are not decoded.
// The slave is zero-wait except for the two-cycle ERROR response.
`timescale 1ns/1ps

module comm_blk_top (
  input  logic        HCLK,
  input  logic        HRESETN,
  input  logic        HSEL,
  input  logic [31:0] HADDR,
  input  logic [1:0]  HTRANS,
  input  logic        HWRITE,
  input  logic [2:0]  HSIZE,
  input  logic [2:0]  HBURST,
  input  logic [31:0] HWDATA,
  output logic        HREADY,
  output logic        HRESP,
  output logic [31:0] HRDATA,
  output logic        comm_blk_int
);

  // Bus side to register file
  comm_blk_pkg::reg_sel_t wr_sel;
  comm_blk_pkg::reg_sel_t rd_sel;
  logic [31:0]            rd_data;

  // Register file to sequencer
  logic [comm_blk_pkg::CMD_CODE_W-1:0] cmd_code;
  logic                   start;
  logic                   status_rd;
  logic                   frame8_rd;
  logic                   data8_rd;
  logic                   data32_rd;
  logic                   cmd_flag;
  logic                   rx_ok;
  comm_blk_pkg::phase_t   phase;
  logic [31:0]            resp_word;

  ahb_slave_if u_ahb (
    .HCLK, .HRESETN, .HSEL, .HADDR, .HTRANS, .HWRITE,
    .rd_data, .HREADY, .HRESP, .HRDATA, .wr_sel, .rd_sel
  );

  comm_blk_regs u_regs (
    .HCLK, .HRESETN, .wr_sel, .rd_sel, .HWDATA,
    .cmd_flag, .rx_ok, .phase, .resp_word,
    .rd_data, .cmd_code, .start,
    .status_rd, .frame8_rd, .data8_rd, .data32_rd, .comm_blk_int
  );

  response_sequencer u_seq (
    .HCLK, .HRESETN, .start, .cmd_code,
    .status_rd, .frame8_rd, .data8_rd, .data32_rd,
    .cmd_flag, .rx_ok, .phase, .resp_word
  );

endmodule

// File: bench/tb_clock_gen.sv
// Free-running testbench clock, 20 ns period.
// Starts low at time zero.
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk
);

  localparam realtime HALF_PERIOD = 10.0;

  initial clk = 1'b0;

  always #(HALF_PERIOD) clk = ~clk;

endmodule

// File: bench/comm_blk_assert.sv
// Protocol and sequencer checks, bound into the top level.
// Checks are disabled while HRESETN is low.
`timescale 1ns/1ps

module comm_blk_assert (
  input logic                 HCLK,
  input logic                 HRESETN,
  input logic                 HREADY,
  input logic                 HRESP,
  input logic                 cmd_flag,
  input logic                 rx_ok,
  input comm_blk_pkg::phase_t phase
);

  // ERROR response is two cycles, wait state first
  err_two_cycle: assert property (@(posedge HCLK) disable iff (!HRESETN)
    !HREADY |-> HRESP ##1 (HRESP && HREADY))
    else $error("ERROR response not two cycles");

  cmd_needs_rx: assert property (@(posedge HCLK) disable iff (!HRESETN)
    cmd_flag |-> rx_ok)
    else $error("cmd_flag without rx_ok");

  phase_range: assert property (@(posedge HCLK) disable iff (!HRESETN)
    phase <= 3'd3)
    else $error("phase out of range");

endmodule

bind comm_blk_top comm_blk_assert u_assert (
  .HCLK, .HRESETN, .HREADY, .HRESP, .cmd_flag, .rx_ok, .phase
);

// File: bench/tb_comm_blk.sv
// Testbench for the communication block, single AHB NONSEQ transfers only.
// Inputs change on the rising edge, outputs are sampled on the falling edge.
// Expected values come from a register model kept in this file.
`timescale 1ns/1ps

module tb_comm_blk;

  localparam int   CLK_NS    = 20;
  localparam int   POLL_MAX  = comm_blk_pkg::RESP_DELAY + 4;
  localparam int   WD_CYCLES = 400 + 300 + 300 + 300 + 200 + 500; // Test budgets, margin
  localparam logic [31:0] BASE = comm_blk_pkg::COMM_BASE;

  logic HCLK, HRESETN, HSEL, HWRITE, HREADY, HRESP, comm_blk_int;
  logic [31:0] HADDR, HWDATA, HRDATA;
  logic [1:0]  HTRANS;
  logic [2:0]  HSIZE, HBURST;

  integer seed = 32'hea2f62cf;
  int     errors = 0;
  int     checks = 0;
  int     tests  = 0;
  int     err_at_start;

  // Register model
  logic [7:0]  m_control, m_status_sw, m_int_enable, m_data8, m_frame8;
  logic [31:0] m_data32;

  tb_clock_gen u_clk (.clk(HCLK));

  comm_blk_top uut (
    .HCLK, .HRESETN, .HSEL, .HADDR, .HTRANS, .HWRITE, .HSIZE, .HBURST,
    .HWDATA, .HREADY, .HRESP, .HRDATA, .comm_blk_int
  );

  // ====================
  // Helpers
  // ====================
  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report(input string what);
    $display("ERROR t=%0t %s", $time, what);
    errors++;
  endtask

  task automatic ahb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    @(posedge HCLK);
    HSEL   <= 1'b1;
    HTRANS <= 2'b10;   // NONSEQ
    HWRITE <= wr;
    HADDR  <= addr;
    @(posedge HCLK);
    HSEL   <= 1'b0;
    HTRANS <= 2'b00;
    HWDATA <= wr ? wdata : 32'h0;
    @(negedge HCLK);
    rdata = HRDATA;
    err   = 1'b0;
    if (!HREADY) begin
      err = 1'b1;
      if (!HRESP)
        report("HRESP low during the ERROR wait state");
      @(negedge HCLK);
      if (!(HREADY && HRESP))
        report("second ERROR cycle missing");
    end else if (HRESP) begin
      report("HRESP high with HREADY high and no wait state");
    end
  endtask

  task automatic reg_write(input logic [11:0] off, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    ahb_xfer(1'b1, {BASE[31:12], off}, data, rd, err);
    if (err)
      report("unexpected ERROR response on a register write");
  endtask

  task automatic reg_read(input logic [11:0] off, output logic [31:0] data);
    logic err;
    ahb_xfer(1'b0, {BASE[31:12], off}, 32'h0, data, err);
    if (err)
      report("unexpected ERROR response on a register read");
  endtask

  function automatic logic [7:0] status_exp();
    return (m_status_sw & 8'h7C) | 8'h01;   // Flags clear, tx_ok set
  endfunction

  // True for the offsets that hold a register
  function automatic logic offset_mapped(input logic [11:0] off);
    return off == comm_blk_pkg::OFF_CONTROL || off == comm_blk_pkg::OFF_STATUS ||
           off == comm_blk_pkg::OFF_INT_ENABLE || off == comm_blk_pkg::OFF_DATA8 ||
           off == comm_blk_pkg::OFF_DATA32 || off == comm_blk_pkg::OFF_FRAME8;
  endfunction

  // Polls status until all mask bits are set, ok shows whether that happened
  task automatic poll_status(input logic [7:0] mask, output logic ok);
    logic [31:0] v;
    int          n;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < POLL_MAX) begin
      reg_read(comm_blk_pkg::OFF_STATUS, v);
      ok = ((v[7:0] & mask) == mask);
      n++;
    end
  endtask

  function automatic logic code_known(input logic [7:0] code);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < comm_blk_pkg::NUM_DESC_CMDS; i++)
      if (comm_blk_pkg::DESC_CMDS[i] == code) hit = 1'b1;
    for (int i = 0; i < comm_blk_pkg::NUM_SHORT_CMDS; i++)
      if (comm_blk_pkg::SHORT_CMDS[i] == code) hit = 1'b1;
    return hit;
  endfunction

  task automatic check_all_regs();
    logic [31:0] v;
    reg_read(comm_blk_pkg::OFF_CONTROL, v);
    check_value("control", v, {24'h0, m_control});
    reg_read(comm_blk_pkg::OFF_STATUS, v);
    check_value("status", v, {24'h0, status_exp()});
    reg_read(comm_blk_pkg::OFF_INT_ENABLE, v);
    check_value("int_enable", v, {24'h0, m_int_enable});
    reg_read(comm_blk_pkg::OFF_DATA8, v);
    check_value("data8", v, {24'h0, m_data8});
    reg_read(comm_blk_pkg::OFF_DATA32, v);
    check_value("data32", v, m_data32);
    reg_read(comm_blk_pkg::OFF_FRAME8, v);
    check_value("frame8", v, {24'h0, m_frame8});
  endtask

  task automatic begin_test();
    err_at_start = errors;
    tests++;
  endtask

  task automatic end_test(input string name);
    if (errors == err_at_start)
      $display("test %0d %s: ok", tests, name);
    else
      $display("test %0d %s: %0d errors", tests, name, errors - err_at_start);
  endtask

  // Two- or three-phase response after the service has started
  task automatic run_service(input logic [7:0] code, input logic desc);
    logic [31:0] v;
    logic        ok;
    poll_status(8'h82, ok);
    if (!ok) report("no response: cmd and rx_ok never set");
    reg_read(comm_blk_pkg::OFF_STATUS, v);
    reg_read(comm_blk_pkg::OFF_FRAME8, v);
    check_value("frame8 echo", v, {24'h0, code});
    poll_status(8'h02, ok);
    if (!ok) report("no response: rx_ok missing in phase 2");
    reg_read(comm_blk_pkg::OFF_STATUS, v);
    reg_read(comm_blk_pkg::OFF_DATA8, v);
    check_value("data8 status", v, {24'h0, comm_blk_pkg::RESP_STATUS_OK});
    if (desc) begin
      poll_status(8'h02, ok);
      if (!ok) report("no response: rx_ok missing in phase 3");
      reg_read(comm_blk_pkg::OFF_STATUS, v);
      reg_read(comm_blk_pkg::OFF_DATA32, v);
      check_value("data32 descriptor", v,
                  comm_blk_pkg::DESC_BASE + {24'h0, code} * comm_blk_pkg::DESC_STRIDE);
    end
  endtask

  // ====================
  // Watchdog
  // ====================
  initial begin
    #(WD_CYCLES * CLK_NS);
    $display("Timeout: run exceeded %0d cycles", WD_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // ====================
  // Tests
  // ====================
  initial begin
    logic [31:0] v, addr, wd;
    logic [7:0]  code;
    logic        err, ok;
    int          pick;

    HRESETN = 1'b0;
    HSEL = 1'b0;
    HADDR = '0;
    HTRANS = 2'b00;
    HWRITE = 1'b0;
    HSIZE = 3'b010;
    HBURST = 3'b000;
    HWDATA = '0;
    m_control = comm_blk_pkg::CONTROL_RESET;
    m_status_sw = 8'h00;
    m_int_enable = comm_blk_pkg::INT_ENABLE_RESET;
    m_data8 = 8'h00;
    m_data32 = 32'h0;
    m_frame8 = 8'h00;
    repeat (10) @(posedge HCLK);
    HRESETN <= 1'b1;

    // 1: reset values and masked write/read-back
    begin_test();
    reg_read(comm_blk_pkg::OFF_CONTROL, v);
    check_value("control", v, 32'h1C);
    reg_read(comm_blk_pkg::OFF_STATUS, v);
    check_value("status", v, 32'h01);
    reg_read(comm_blk_pkg::OFF_INT_ENABLE, v);
    check_value("int_enable", v, 32'hAF);
    reg_write(comm_blk_pkg::OFF_FRAME8, 32'h02);  // Unknown code, data8 writes stay idle
    m_frame8 = 8'h02;
    for (int i = 0; i < 20; i++) begin
      pick = $unsigned($random(seed)) % 5;
      wd   = $random(seed);
      case (pick)
        0: begin
          reg_write(comm_blk_pkg::OFF_CONTROL, wd);
          m_control = (m_control & 8'hC2) | (wd[7:0] & 8'h3D);
          reg_read(comm_blk_pkg::OFF_CONTROL, v);
          check_value("control", v, {24'h0, m_control});
        end
        1: begin
          reg_write(comm_blk_pkg::OFF_STATUS, wd);
          m_status_sw = wd[7:0] & 8'h7C;
          reg_read(comm_blk_pkg::OFF_STATUS, v);
          check_value("status", v, {24'h0, status_exp()});
        end
        2: begin
          reg_write(comm_blk_pkg::OFF_INT_ENABLE, wd);
          m_int_enable = wd[7:0];
          reg_read(comm_blk_pkg::OFF_INT_ENABLE, v);
          check_value("int_enable", v, {24'h0, m_int_enable});
        end
        3: begin
          reg_write(comm_blk_pkg::OFF_DATA8, wd);
          m_data8 = wd[7:0];
          reg_read(comm_blk_pkg::OFF_DATA8, v);
          check_value("data8", v, {24'h0, m_data8});
        end
        default: begin
          reg_write(comm_blk_pkg::OFF_DATA32, wd);
          m_data32 = wd;
          reg_read(comm_blk_pkg::OFF_DATA32, v);
          check_value("data32", v, m_data32);
        end
      endcase
    end
    end_test("reset and read-back");

    // 2: holes in the window and register offsets outside it
    begin_test();
    for (int i = 0; i < 10; i++) begin
      addr = $random(seed);
      if (i[1]) begin
        addr[31:12] = BASE[31:12];   // Inside the window, on no register
        while (offset_mapped(addr[11:0]))
          addr[11:0] = $random(seed);
      end else begin
        addr[11:0] = 12'(4 * ($unsigned($random(seed)) % 7)); // Word offset, other window
        while (addr[31:12] == BASE[31:12])
          addr[31:12] = $random(seed);
      end
      ahb_xfer(i[0], addr, $random(seed), v, err);
      if (!err)
        report($sformatf("no ERROR response for address %h", addr));
    end
    check_all_regs();
    end_test("error response");

    // 3: three-phase descriptor service
    begin_test();
    code = comm_blk_pkg::DESC_CMDS[$unsigned($random(seed)) % comm_blk_pkg::NUM_DESC_CMDS];
    wd = $random(seed);
    reg_write(comm_blk_pkg::OFF_FRAME8, {24'h0, code});
    reg_write(comm_blk_pkg::OFF_DATA8, wd);
    m_frame8 = code;
    m_data8  = wd[7:0];
    run_service(code, 1'b1);
    reg_read(comm_blk_pkg::OFF_STATUS, v);
    check_value("status cmd/rx_ok", {30'h0, v[7], v[1]}, 32'h0);
    end_test("descriptor service");

    // 4: self-test started by frame8 alone, then an unknown code
    begin_test();
    code = ($random(seed) & 1) ? 8'd40 : 8'd45;
    reg_write(comm_blk_pkg::OFF_FRAME8, {24'h0, code});
    run_service(code, 1'b0);
    poll_status(8'h02, ok);
    if (ok) report("rx_ok raised after the self-test service ended");
    code = $random(seed);
    while (code_known(code))
      code = $random(seed);
    reg_write(comm_blk_pkg::OFF_FRAME8, {24'h0, code});
    reg_write(comm_blk_pkg::OFF_DATA8, $random(seed));
    poll_status(8'h02, ok);
    if (ok) report($sformatf("rx_ok raised for unknown code %0d", code));
    end_test("self-test service");

    // 5: interrupt is OR of enable AND status
    begin_test();
    for (int i = 0; i < 8; i++) begin
      wd = $random(seed);
      reg_write(comm_blk_pkg::OFF_INT_ENABLE, wd);
      m_int_enable = wd[7:0];
      wd = $random(seed);
      reg_write(comm_blk_pkg::OFF_STATUS, wd);
      m_status_sw = wd[7:0] & 8'h7C;
      repeat (2) @(posedge HCLK);
      @(negedge HCLK);
      check_value("comm_blk_int", {31'h0, comm_blk_int},
                  {31'h0, |(m_int_enable & status_exp())});
    end
    end_test("interrupt");

    $display("tests=%0d checks=%0d errors=%0d", tests, checks, errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// File: filelist.f
source/comm_blk_pkg.sv
source/ahb_slave_if.sv
source/comm_blk_regs.sv
source/response_sequencer.sv
source/comm_blk_top.sv
bench/tb_clock_gen.sv
bench/comm_blk_assert.sv
bench/tb_comm_blk.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_comm_blk
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^TESTBENCH PASSED$$"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
